// File: files.f
+incdir+tests
source/fpu_sqrt_pkg.sv
source/shift_register.sv
source/elastic_buffer.sv
source/fsqrt_pe.sv
source/pe_serializer.sv
source/fpu_sqrt.sv
tests/fpu_sqrt_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for failure
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module fpu_sqrt_tb \
    -f files.f -o fpu_sqrt_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/fpu_sqrt_sim > sim.log 2>&1 || echo "Simulator returned a failing status"
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0

// File: source/elastic_buffer.sv
// Two-entry valid/ready buffer with a registered ready toward the sender
`timescale 1ns/10ps

module elastic_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_in,
    output logic     ready_in,
    input  payload_t data_in,
    output logic     valid_out,
    input  logic     ready_out,
    output payload_t data_out
);

    // The skid entry catches the one beat that arrives while the output stalls
    logic     skid_valid;
    payload_t skid_data;

    assign ready_in = ~skid_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!skid_valid) begin
            if (!valid_out || ready_out) begin
                valid_out <= valid_in;
            end else if (valid_in) begin
                skid_valid <= 1'b1;
            end
        end else if (ready_out) begin
            // Skid entry drains into the output register, input reopens next cycle
            valid_out  <= 1'b1;
            skid_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!skid_valid) begin
            if (!valid_out || ready_out) begin
                data_out <= data_in;
            end else begin
                skid_data <= data_in;
            end
        end else if (ready_out) begin
            data_out <= skid_data;
        end
    end

endmodule

// File: source/fpu_sqrt.sv
// SIMD single-precision square-root unit that time-shares lanes over pipelined PEs
`timescale 1ns/10ps

module fpu_sqrt (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               valid_in,
    output logic                                               ready_in,
    input  logic [fpu_sqrt_pkg::num_lanes-1:0]                 mask_in,
    input  logic [fpu_sqrt_pkg::tag_width-1:0]                 tag_in,
    input  logic [fpu_sqrt_pkg::frm_bits-1:0]                  frm,
    input  logic [fpu_sqrt_pkg::num_lanes-1:0][31:0]           dataa,
    output logic [fpu_sqrt_pkg::num_lanes-1:0][31:0]           result,
    output logic [fpu_sqrt_pkg::flags_bits-1:0]                fflags,
    output logic [fpu_sqrt_pkg::tag_width-1:0]                 tag_out,
    output logic                                               valid_out,
    input  logic                                               ready_out
);

    fpu_sqrt_pkg::pe_req_t [fpu_sqrt_pkg::num_lanes-1:0] lane_req;
    fpu_sqrt_pkg::pe_rsp_t [fpu_sqrt_pkg::num_lanes-1:0] lane_rsp;
    fpu_sqrt_pkg::pe_req_t [fpu_sqrt_pkg::num_pes-1:0]   pe_req;
    fpu_sqrt_pkg::pe_rsp_t [fpu_sqrt_pkg::num_pes-1:0]   pe_rsp;

    logic                                  pe_enable;
    logic [fpu_sqrt_pkg::num_lanes-1:0]    mask_out;
    fpu_sqrt_pkg::fflags_t                 merged_flags;

    // The rounding mode rides with every lane so each PE stage sees its own copy
    for (genvar i = 0; i < fpu_sqrt_pkg::num_lanes; i++) begin : g_lane_req
        assign lane_req[i].data = dataa[i];
        assign lane_req[i].frm  = frm;
    end

    pe_serializer #(
        .TAG_W (fpu_sqrt_pkg::num_lanes + fpu_sqrt_pkg::tag_width)
    ) u_serializer (
        .clk         (clk),
        .rst         (rst),
        .valid_in    (valid_in),
        .ready_in    (ready_in),
        .data_in     (lane_req),
        .tag_in      ({mask_in, tag_in}),
        .pe_enable   (pe_enable),
        .pe_data_out (pe_req),
        .pe_data_in  (pe_rsp),
        .valid_out   (valid_out),
        .ready_out   (ready_out),
        .data_out    (lane_rsp),
        .tag_out     ({mask_out, tag_out})
    );

    for (genvar i = 0; i < fpu_sqrt_pkg::num_pes; i++) begin : g_pe
        fsqrt_pe u_pe (
            .clk    (clk),
            .rst    (rst),
            .enable (pe_enable),
            .req    (pe_req[i]),
            .rsp    (pe_rsp[i])
        );
    end

    for (genvar i = 0; i < fpu_sqrt_pkg::num_lanes; i++) begin : g_result
        assign result[i] = lane_rsp[i].data;
    end

    // Only lanes that were active in the request contribute flags
    always_comb begin
        merged_flags = '0;
        for (int i = 0; i < fpu_sqrt_pkg::num_lanes; i++) begin
            if (mask_out[i]) begin
                merged_flags = merged_flags | lane_rsp[i].flags;
            end
        end
    end

    assign fflags = merged_flags;

endmodule

// File: source/fpu_sqrt_pkg.sv
// Shared sizes, encodings and payload types for the SIMD floating-point square-root unit
package fpu_sqrt_pkg;

    // Lane group and processing-element layout
    localparam int num_lanes = 4;
    localparam int num_pes   = 2;
    localparam int num_beats = num_lanes / num_pes;
    localparam int beat_bits = (num_beats > 1) ? $clog2(num_beats) : 1;

    // Processing-element pipeline depth, first and last stages included
    localparam int latency_fsqrt = 8;
    localparam int sqrt_stages   = latency_fsqrt - 2;

    // Root bits: 24 significand bits, a guard bit and one more for the sticky
    localparam int root_bits = 26;

    localparam int tag_width = 6;

    // Rounding modes
    localparam int frm_bits = 3;
    localparam logic [frm_bits-1:0] frm_rne = 3'd0;
    localparam logic [frm_bits-1:0] frm_rtz = 3'd1;
    localparam logic [frm_bits-1:0] frm_rdn = 3'd2;
    localparam logic [frm_bits-1:0] frm_rup = 3'd3;
    localparam logic [frm_bits-1:0] frm_rmm = 3'd4;

    localparam int flags_bits = 5;

    localparam logic [31:0] canonical_nan = 32'h7FC0_0000;
    localparam logic [31:0] pos_inf       = 32'h7F80_0000;

    // Exception flags, high bit first
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef struct packed {
        logic [31:0]         data;
        logic [frm_bits-1:0] frm;
    } pe_req_t;

    typedef struct packed {
        logic [31:0] data;
        fflags_t     flags;
    } pe_rsp_t;

endpackage

// File: source/fsqrt_pe.sv
// Pipelined single-precision square root with rounding and exception flags
`timescale 1ns/10ps

module fsqrt_pe (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  fpu_sqrt_pkg::pe_req_t req,
    output fpu_sqrt_pkg::pe_rsp_t rsp
);

    typedef struct packed {
        logic [fpu_sqrt_pkg::frm_bits-1:0]     frm;
        logic                                  special;
        logic [31:0]                           special_val;
        logic                                  special_nv;
        logic [7:0]                            exp;
        logic [2*fpu_sqrt_pkg::root_bits-1:0]  rad;
        logic [fpu_sqrt_pkg::root_bits+1:0]    rem;
        logic [fpu_sqrt_pkg::root_bits-1:0]    root;
    } stage_t;

    // Decode the operand and set up the radicand with an even exponent
    function automatic stage_t classify(input fpu_sqrt_pkg::pe_req_t r);
        stage_t      s;
        logic [7:0]  e;
        logic [22:0] f;
        logic [8:0]  exp_sum;
        logic [24:0] m_adj;
        e = r.data[30:23];
        f = r.data[22:0];
        s = '0;
        s.frm = r.frm;
        // Halved biased exponent, rounding down for odd unbiased exponents
        exp_sum = {1'b0, e} + 9'd126 + {8'd0, e[0]};
        s.exp = exp_sum[8:1];
        m_adj = e[0] ? {2'b01, f} : {1'b1, f, 1'b0};
        s.rad = {m_adj, {(2*fpu_sqrt_pkg::root_bits-25){1'b0}}};
        if (e == 8'hFF && f != '0) begin
            s.special     = 1'b1;
            s.special_val = fpu_sqrt_pkg::canonical_nan;
            s.special_nv  = ~f[22];
        end else if (e == 8'h00) begin
            // Zero, and subnormals flushed to zero of the same sign
            s.special     = 1'b1;
            s.special_val = {r.data[31], 31'd0};
        end else if (r.data[31]) begin
            s.special     = 1'b1;
            s.special_val = fpu_sqrt_pkg::canonical_nan;
            s.special_nv  = 1'b1;
        end else if (e == 8'hFF) begin
            s.special     = 1'b1;
            s.special_val = fpu_sqrt_pkg::pos_inf;
        end
        return s;
    endfunction

    // One restoring step: bring down two radicand bits and try 4q+1
    function automatic stage_t root_step(input stage_t s_in);
        stage_t                             s;
        logic [fpu_sqrt_pkg::root_bits+1:0] shifted;
        logic [fpu_sqrt_pkg::root_bits+1:0] trial;
        s = s_in;
        shifted = {s.rem[fpu_sqrt_pkg::root_bits-1:0], s.rad[2*fpu_sqrt_pkg::root_bits-1 -: 2]};
        trial = {s.root, 2'b01};
        if (shifted >= trial) begin
            s.rem  = shifted - trial;
            s.root = {s.root[fpu_sqrt_pkg::root_bits-2:0], 1'b1};
        end else begin
            s.rem  = shifted;
            s.root = {s.root[fpu_sqrt_pkg::root_bits-2:0], 1'b0};
        end
        s.rad = s.rad << 2;
        return s;
    endfunction

    // Root bits produced by a middle stage, the early stages take the remainder
    function automatic int root_steps(input int stage);
        return fpu_sqrt_pkg::root_bits / fpu_sqrt_pkg::sqrt_stages
            + ((stage <= fpu_sqrt_pkg::root_bits % fpu_sqrt_pkg::sqrt_stages) ? 1 : 0);
    endfunction

    function automatic fpu_sqrt_pkg::pe_rsp_t round_result(input stage_t s);
        fpu_sqrt_pkg::pe_rsp_t r;
        logic [23:0]           mant;
        logic                  guard;
        logic                  sticky;
        logic                  inexact;
        logic                  round_up;
        logic [24:0]           mant_r;
        logic [7:0]            exp_r;
        mant = s.root[fpu_sqrt_pkg::root_bits-1 -: 24];
        guard = s.root[fpu_sqrt_pkg::root_bits-25];
        sticky = (|s.root[fpu_sqrt_pkg::root_bits-26:0]) | (|s.rem);
        inexact = guard | sticky;
        // The root is positive here, so RDN truncates and RUP rounds away
        case (s.frm)
            fpu_sqrt_pkg::frm_rtz, fpu_sqrt_pkg::frm_rdn: round_up = 1'b0;
            fpu_sqrt_pkg::frm_rup: round_up = inexact;
            fpu_sqrt_pkg::frm_rmm: round_up = guard;
            default: round_up = guard & (sticky | mant[0]);
        endcase
        mant_r = {1'b0, mant} + {24'd0, round_up};
        exp_r = s.exp + {7'd0, mant_r[24]};
        r = '0;
        if (s.special) begin
            r.data     = s.special_val;
            r.flags.nv = s.special_nv;
        end else begin
            r.data     = {1'b0, exp_r, mant_r[22:0]};
            r.flags.nx = inexact;
        end
        return r;
    endfunction

    stage_t pipe [0:fpu_sqrt_pkg::sqrt_stages];
    stage_t nxt  [1:fpu_sqrt_pkg::sqrt_stages];

    always_comb begin
        for (int k = 1; k <= fpu_sqrt_pkg::sqrt_stages; k++) begin
            nxt[k] = pipe[k-1];
            for (int j = 0; j < root_steps(k); j++) begin
                nxt[k] = root_step(nxt[k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            pipe[0] <= classify(req);
            for (int k = 1; k <= fpu_sqrt_pkg::sqrt_stages; k++) begin
                pipe[k] <= nxt[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp <= '0;
        end else if (enable) begin
            rsp <= round_result(pipe[fpu_sqrt_pkg::sqrt_stages]);
        end
    end

endmodule

// File: source/pe_serializer.sv
// Issues a lane vector over the processing elements in beats and regathers the results
`timescale 1ns/10ps

module pe_serializer #(
    parameter int TAG_W = 1
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 valid_in,
    output logic                                                 ready_in,
    input  fpu_sqrt_pkg::pe_req_t [fpu_sqrt_pkg::num_lanes-1:0]  data_in,
    input  logic [TAG_W-1:0]                                     tag_in,
    output logic                                                 pe_enable,
    output fpu_sqrt_pkg::pe_req_t [fpu_sqrt_pkg::num_pes-1:0]    pe_data_out,
    input  fpu_sqrt_pkg::pe_rsp_t [fpu_sqrt_pkg::num_pes-1:0]    pe_data_in,
    output logic                                                 valid_out,
    input  logic                                                 ready_out,
    output fpu_sqrt_pkg::pe_rsp_t [fpu_sqrt_pkg::num_lanes-1:0]  data_out,
    output logic [TAG_W-1:0]                                     tag_out
);

    typedef struct packed {
        fpu_sqrt_pkg::pe_rsp_t [fpu_sqrt_pkg::num_lanes-1:0] data;
        logic [TAG_W-1:0]                                    tag;
    } out_t;

    logic [fpu_sqrt_pkg::beat_bits-1:0] beat_idx;
    logic [fpu_sqrt_pkg::beat_bits-1:0] exit_idx;
    logic                               beat_last;

    logic [TAG_W+1:0] pipe_word;
    logic             pipe_valid;
    logic             pipe_last;
    logic [TAG_W-1:0] pipe_tag;

    fpu_sqrt_pkg::pe_rsp_t [fpu_sqrt_pkg::num_lanes-1:0] hold;
    fpu_sqrt_pkg::pe_rsp_t [fpu_sqrt_pkg::num_lanes-1:0] merged;

    logic buf_ready;
    out_t buf_in;
    out_t buf_out;

    assign beat_last = (beat_idx == fpu_sqrt_pkg::beat_bits'(fpu_sqrt_pkg::num_beats - 1));

    // Stall only when a finished vector cannot be handed to the output buffer
    assign pe_enable = ~(pipe_valid & pipe_last & ~buf_ready);
    assign ready_in  = pe_enable & beat_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_idx <= '0;
        end else if (pe_enable && valid_in) begin
            beat_idx <= beat_last ? '0 : beat_idx + 1'b1;
        end
    end

    for (genvar i = 0; i < fpu_sqrt_pkg::num_pes; i++) begin : g_issue
        assign pe_data_out[i] = data_in[int'(beat_idx) * fpu_sqrt_pkg::num_pes + i];
    end

    shift_register #(
        .WIDTH (TAG_W + 2),
        .DEPTH (fpu_sqrt_pkg::latency_fsqrt)
    ) u_track (
        .clk      (clk),
        .rst      (rst),
        .enable   (pe_enable),
        .data_in  ({valid_in, beat_last, tag_in}),
        .data_out (pipe_word)
    );

    assign pipe_valid = pipe_word[TAG_W+1];
    assign pipe_last  = pipe_word[TAG_W];
    assign pipe_tag   = pipe_word[TAG_W-1:0];

    // Beats leave the pipeline in issue order, so a counter gives their lane group
    always_ff @(posedge clk) begin
        if (rst) begin
            exit_idx <= '0;
        end else if (pe_enable && pipe_valid) begin
            exit_idx <= pipe_last ? '0 : exit_idx + 1'b1;
        end
    end

    always_comb begin
        merged = hold;
        for (int i = 0; i < fpu_sqrt_pkg::num_pes; i++) begin
            merged[int'(exit_idx) * fpu_sqrt_pkg::num_pes + i] = pe_data_in[i];
        end
    end

    always_ff @(posedge clk) begin
        if (pe_enable && pipe_valid) begin
            hold <= merged;
        end
    end

    assign buf_in.data = merged;
    assign buf_in.tag  = pipe_tag;

    elastic_buffer #(
        .payload_t (out_t)
    ) u_out_buf (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (pipe_valid & pipe_last),
        .ready_in  (buf_ready),
        .data_in   (buf_in),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .data_out  (buf_out)
    );

    assign data_out = buf_out.data;
    assign tag_out  = buf_out.tag;

endmodule

// File: source/shift_register.sv
// Enable-gated delay line that tracks side information next to a stalled pipeline
`timescale 1ns/10ps

module shift_register #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    logic [WIDTH-1:0] stages [DEPTH];

    // Every stage is cleared so no stale valid bit can reach the output
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < DEPTH; k++) begin
                stages[k] <= '0;
            end
        end else if (enable) begin
            stages[0] <= data_in;
            for (int k = 1; k < DEPTH; k++) begin
                stages[k] <= stages[k-1];
            end
        end
    end

    assign data_out = stages[DEPTH-1];

endmodule

// File: tests/sqrt_ref.svh
// Reference square root for one lane, computed in double precision and rounded to single
`ifndef SQRT_REF_SVH
`define SQRT_REF_SVH

// Widens a normal single-precision value to a real
function automatic real single_to_real(input logic [31:0] a);
    return $bitstoreal({a[31], 11'({3'd0, a[30:23]} + 11'd896), a[22:0], 29'd0});
endfunction

// Rounds a positive normal double to single precision under a rounding mode
function automatic logic [31:0] round_to_single(input logic [63:0] d, input logic [2:0] rm);
    logic        guard;
    logic        sticky;
    logic        up;
    logic [24:0] mant_r;
    guard = d[28];
    sticky = |d[27:0];
    case (rm)
        fpu_sqrt_pkg::frm_rne: up = guard & (sticky | d[29]);
        fpu_sqrt_pkg::frm_rup: up = guard | sticky;
        fpu_sqrt_pkg::frm_rmm: up = guard;
        default: up = 1'b0;
    endcase
    mant_r = {2'b01, d[51:29]} + {24'd0, up};
    return {1'b0, 8'(d[62:52] - 11'd896) + {7'd0, mant_r[24]}, mant_r[22:0]};
endfunction

// Expected flags and value of one lane, packed as {nv, dz, of, uf, nx, value}
function automatic logic [36:0] expected_sqrt(input logic [31:0] a, input logic [2:0] rm);
    logic [63:0] d_root;
    logic [31:0] res;
    logic        nx;
    if (a[30:23] == 8'hFF && a[22:0] != 23'd0) begin
        // Signaling NaNs have the quiet bit clear
        return {~a[22], 4'd0, 32'h7FC0_0000};
    end
    if (a[30:23] == 8'h00) begin
        return {5'd0, a[31], 31'd0};
    end
    if (a[31]) begin
        return {5'b10000, 32'h7FC0_0000};
    end
    if (a[30:23] == 8'hFF) begin
        return {5'd0, 32'h7F80_0000};
    end
    d_root = $realtobits($sqrt(single_to_real(a)));
    res = round_to_single(d_root, rm);
    // Bits lost below single precision, or a rounded root that does not square back
    nx = (|d_root[28:0]) || (single_to_real(res) * single_to_real(res) != single_to_real(a));
    return {4'd0, nx, res};
endfunction

`endif

// File: tests/fpu_sqrt_tb.sv
// Testbench for the SIMD square-root unit with a reference scoreboard and random back-pressure
`timescale 1ns/10ps

module fpu_sqrt_tb;

    localparam int nl = fpu_sqrt_pkg::num_lanes;
    localparam int res_w = nl * 32;
    localparam int exp_w = fpu_sqrt_pkg::tag_width + fpu_sqrt_pkg::flags_bits + res_w;
    // Roughly four times the cycles that all phases together need
    localparam int timeout_cycles = 20000;
    // Far more than the pipeline and output buffer can hold without back-pressure
    localparam int drain_limit = 200;

    logic                                  clk;
    logic                                  rst;
    logic                                  valid_in;
    logic                                  ready_in;
    logic [nl-1:0]                         mask_in;
    logic [fpu_sqrt_pkg::tag_width-1:0]    tag_in;
    logic [fpu_sqrt_pkg::frm_bits-1:0]     frm;
    logic [nl-1:0][31:0]                   dataa;
    logic [nl-1:0][31:0]                   result;
    logic [fpu_sqrt_pkg::flags_bits-1:0]   fflags;
    logic [fpu_sqrt_pkg::tag_width-1:0]    tag_out;
    logic                                  valid_out;
    logic                                  ready_out;

    integer                             seed;
    logic                               random_ready;
    int                                 cycle_count;
    int                                 burst_start;
    logic [fpu_sqrt_pkg::tag_width-1:0] next_tag;
    logic [nl-1:0][31:0]                ops;
    logic [exp_w-1:0]                   exp_word;
    logic [exp_w-1:0]                   exp_q [$];

    `include "sqrt_ref.svh"

    fpu_sqrt uut (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .mask_in   (mask_in),
        .tag_in    (tag_in),
        .frm       (frm),
        .dataa     (dataa),
        .result    (result),
        .fflags    (fflags),
        .tag_out   (tag_out),
        .valid_out (valid_out),
        .ready_out (ready_out)
    );

    always #5 clk = ~clk;

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "Check failed");
    endtask

    function automatic logic [31:0] random_normal();
        logic [7:0] e;
        e = 8'($random(seed));
        if (e == 8'h00) e = 8'h01;
        if (e == 8'hFF) e = 8'hFE;
        return {1'b0, e, 23'($random(seed))};
    endfunction

    // A root with a 12-bit significand squares exactly into single precision
    function automatic logic [31:0] perfect_square();
        logic [31:0] r;
        r = {1'b0, 8'd100 + 8'($random(seed) & 63), 11'($random(seed)), 12'd0};
        return round_to_single($realtobits(single_to_real(r) * single_to_real(r)),
                               fpu_sqrt_pkg::frm_rtz);
    endfunction

    // Holds one request until it is accepted, then queues what it should return
    task automatic send_request(input logic [nl-1:0] mask, input logic [2:0] rm,
                                input logic [nl-1:0][31:0] lanes);
        logic [36:0]         lane;
        logic [nl-1:0][31:0] exp_res;
        logic [4:0]          exp_flags;
        exp_flags = '0;
        for (int l = 0; l < nl; l++) begin
            lane = expected_sqrt(lanes[l], rm);
            exp_res[l] = lane[31:0];
            if (mask[l]) exp_flags = exp_flags | lane[36:32];
        end
        valid_in <= 1'b1;
        mask_in  <= mask;
        tag_in   <= next_tag;
        frm      <= rm;
        dataa    <= lanes;
        @(posedge clk);
        while (!ready_in) @(posedge clk);
        exp_q.push_back({next_tag, exp_flags, exp_res});
        next_tag = next_tag + 6'd1;
    endtask

    task automatic drain();
        int waited;
        valid_in <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        repeat (20) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (random_ready) ready_out <= 1'($random(seed));
        else ready_out <= 1'b1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    // Every output handshake must match the oldest request still outstanding
    always @(posedge clk) begin
        if (!rst && valid_out && ready_out) begin
            assert (exp_q.size() != 0)
                else stop_on_error("Output handshake seen with no request outstanding");
            exp_word = exp_q.pop_front();
            assert (tag_out == exp_word[exp_w-1 -: fpu_sqrt_pkg::tag_width])
                else stop_on_error($sformatf("mismatch at %0t: tag %0d, expected %0d",
                    $time, tag_out, exp_word[exp_w-1 -: fpu_sqrt_pkg::tag_width]));
            assert (result == exp_word[res_w-1:0])
                else stop_on_error($sformatf("mismatch at %0t: result %h, expected %h",
                    $time, result, exp_word[res_w-1:0]));
            assert (fflags == exp_word[res_w +: fpu_sqrt_pkg::flags_bits])
                else stop_on_error($sformatf("mismatch at %0t: fflags %b, expected %b",
                    $time, fflags, exp_word[res_w +: fpu_sqrt_pkg::flags_bits]));
        end
    end

    initial begin
        seed = 32'h59bc4a24;
        clk = 1'b0;
        rst = 1'b1;
        valid_in = 1'b0;
        mask_in = '0;
        tag_in = '0;
        frm = '0;
        dataa = '0;
        ready_out = 1'b1;
        random_ready = 1'b0;
        cycle_count = 0;
        next_tag = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // Zeros, infinities, NaNs, negatives and subnormals
        send_request(4'hF, fpu_sqrt_pkg::frm_rne, {32'h0000_0000, 32'h8000_0000,
                                                   32'h7F80_0000, 32'h7FC0_0001});
        send_request(4'hF, fpu_sqrt_pkg::frm_rne, {32'h7F80_0001, 32'hC080_0000,
                                                   32'hFF80_0000, 32'h0001_2345});
        send_request(4'b0110, fpu_sqrt_pkg::frm_rup, {32'h8040_0000, 32'hFFC0_0000,
                                                      32'h3F80_0000, 32'h7FA0_0000});
        for (int m = 0; m < 5; m++) begin
            for (int n = 0; n < 100; n++) begin
                for (int l = 0; l < nl; l++) ops[l] = random_normal();
                send_request(4'hF, 3'(m), ops);
            end
        end
        for (int n = 0; n < 25; n++) begin
            for (int l = 0; l < nl; l++) ops[l] = perfect_square();
            send_request(4'hF, 3'(n % 5), ops);
        end
        // Random lane masks under random back-pressure
        random_ready <= 1'b1;
        for (int n = 0; n < 1000; n++) begin
            for (int l = 0; l < nl; l++) ops[l] = random_normal();
            send_request(4'($random(seed)), 3'($unsigned($random(seed)) % 5), ops);
        end
        random_ready <= 1'b0;
        drain();
        // With no back-pressure a request is taken every two cycles
        burst_start = cycle_count;
        for (int n = 0; n < 50; n++) begin
            for (int l = 0; l < nl; l++) ops[l] = random_normal();
            send_request(4'hF, fpu_sqrt_pkg::frm_rne, ops);
        end
        assert (cycle_count - burst_start == 100)
            else stop_on_error("Back-to-back burst was not accepted at one request per two cycles");
        drain();
        if (exp_q.size() != 0) begin
            $display("Requests still outstanding at the end of the run: %0d", exp_q.size());
            $display("Result: FAILED");
            $fatal(1, "Outstanding requests");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule
